//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mix_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert -Wall -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) hdl/mix_consts.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail, since the testbench exit status does not
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/lane_collect.sv
`timescale 1ns/1ps
`include "mix_consts.svh"

module lane_collect (
    input  logic                     clk,
    input  logic                     rst_n,

    // per-lane links
    input  logic [`MIX_NUM_LANES-1:0] i_lane_valid,
    input  mix_pkg::flit_t           i_lane_flit [`MIX_NUM_LANES],
    output logic [`MIX_NUM_LANES-1:0] o_lane_ready,

    // output stream
    output logic                     o_valid,
    output mix_pkg::flit_t           o_flit,
    input  logic                     i_ready
);

    localparam mix_pkg::lane_idx_t LAST_LANE = mix_pkg::lane_idx_t'(`MIX_NUM_LANES - 1);

    mix_pkg::lane_idx_t rd_ptr;
    logic               sel_valid;
    mix_pkg::flit_t     sel_flit;
    logic               reg_ready;
    logic               take;

    // lane under the read pointer feeds the output register
    assign sel_valid = i_lane_valid[rd_ptr];
    assign sel_flit  = i_lane_flit[rd_ptr];
    assign take      = sel_valid && reg_ready;

    // only the selected lane sees the register ready
    always_comb begin
        for (int i = 0; i < `MIX_NUM_LANES; i++) begin
            o_lane_ready[i] = reg_ready && (rd_ptr == mix_pkg::lane_idx_t'(i));
        end
    end

    // same wrap order as the dispatcher keeps flits in order
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (take) begin
            if (rd_ptr == LAST_LANE) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + mix_pkg::lane_idx_t'(1);
            end
        end
    end

    // output skid register drives the stream
    pipe_regs #(
        .DATA_WIDTH ($bits(mix_pkg::flit_t))
    ) u_out_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (sel_valid),
        .o_ready_up (reg_ready),
        .o_valid    (o_valid),
        .i_ready_dn (i_ready),
        .i_data     (sel_flit),
        .o_data     (o_flit)
    );

    // a lane waiting on a full register keeps its turn and its flit
    a_lane_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (sel_valid && !reg_ready) |=> (sel_valid && $stable(sel_flit)));

endmodule

//--- hdl/lane_dispatch.sv
`timescale 1ns/1ps
`include "mix_consts.svh"

module lane_dispatch (
    input  logic                     clk,
    input  logic                     rst_n,

    // input stream
    input  logic                     i_valid,
    input  mix_pkg::flit_t           i_flit,
    output logic                     o_ready,

    // per-lane links
    output logic [`MIX_NUM_LANES-1:0] o_lane_valid,
    output mix_pkg::flit_t           o_lane_flit [`MIX_NUM_LANES],
    input  logic [`MIX_NUM_LANES-1:0] i_lane_ready
);

    localparam mix_pkg::lane_idx_t LAST_LANE = mix_pkg::lane_idx_t'(`MIX_NUM_LANES - 1);

    mix_pkg::lane_idx_t wr_ptr;
    logic               accept;

    // input ready is the ready of the lane being written
    assign o_ready = i_lane_ready[wr_ptr];
    assign accept  = i_valid && o_ready;

    // flit goes out on every lane but valid only on the selected one
    always_comb begin
        for (int i = 0; i < `MIX_NUM_LANES; i++) begin
            o_lane_valid[i] = i_valid && (wr_ptr == mix_pkg::lane_idx_t'(i));
            o_lane_flit[i]  = i_flit;
        end
    end

    // write pointer steps once per accepted flit and wraps after the last lane
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (accept) begin
            if (wr_ptr == LAST_LANE) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + mix_pkg::lane_idx_t'(1);
            end
        end
    end

    // a waiting lane keeps its offer and its flit until it takes them
    a_offer_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (i_valid && !o_ready) |=> ($stable(o_lane_valid) && $stable(i_flit)));

endmodule

//--- hdl/mix_consts.svh
`ifndef MIX_CONSTS_SVH
`define MIX_CONSTS_SVH

// number of parallel mixing lanes, sets lane index width and capacity
`define MIX_NUM_LANES 4

// data word width of one flit
`define MIX_WORD_W 32

// constant added at the end of the mixing round
`define MIX_KEY 32'h9e3779b9

// rotate-left amount of the mixing round
`define MIX_ROT 5

`endif

//--- hdl/mix_lane.sv
`timescale 1ns/1ps
`include "mix_consts.svh"

module mix_lane (
    input  logic           clk,
    input  logic           rst_n,

    // from the dispatcher
    input  logic           i_valid,
    input  mix_pkg::flit_t i_flit,
    output logic           o_ready,

    // to the collector
    output logic           o_valid,
    output mix_pkg::flit_t o_flit,
    input  logic           i_ready
);

    mix_pkg::word_t rot_word;
    mix_pkg::flit_t mixed_flit;

    // rotate left by the fixed amount
    assign rot_word = {i_flit.data[`MIX_WORD_W-1-`MIX_ROT:0],
                       i_flit.data[`MIX_WORD_W-1:`MIX_WORD_W-`MIX_ROT]};

    // mixing round: rotl xor input, then add key mod 2^32
    assign mixed_flit.data = (rot_word ^ i_flit.data) + `MIX_KEY;
    // frame marker is carried through as is
    assign mixed_flit.last = i_flit.last;

    // mix is combinational on entry, so the only latency is the skid register
    pipe_regs #(
        .DATA_WIDTH ($bits(mix_pkg::flit_t))
    ) u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (i_valid),
        .o_ready_up (o_ready),
        .o_valid    (o_valid),
        .i_ready_dn (i_ready),
        .i_data     (mixed_flit),
        .o_data     (o_flit)
    );

endmodule

//--- hdl/mix_pkg.sv
`include "mix_consts.svh"

package mix_pkg;

    // one data word of the stream
    typedef logic [`MIX_WORD_W-1:0] word_t;

    // index of one lane, round-robin pointers use this
    typedef logic [$clog2(`MIX_NUM_LANES)-1:0] lane_idx_t;

    // one flit on every valid/ready link
    // last marks the end of a frame and is never touched
    typedef struct packed {
        word_t data;
        logic  last;
    } flit_t;

endpackage

//--- hdl/mix_top.sv
`timescale 1ns/1ps
`include "mix_consts.svh"

module mix_top (
    input  logic           clk,
    input  logic           rst_n,

    // input stream
    input  logic           i_valid,
    input  mix_pkg::flit_t i_flit,
    output logic           o_ready,

    // output stream
    output logic           o_valid,
    output mix_pkg::flit_t o_flit,
    input  logic           i_ready
);

    // dispatcher to lanes
    logic [`MIX_NUM_LANES-1:0] lane_in_valid;
    mix_pkg::flit_t           lane_in_flit [`MIX_NUM_LANES];
    logic [`MIX_NUM_LANES-1:0] lane_in_ready;

    // lanes to collector
    logic [`MIX_NUM_LANES-1:0] lane_out_valid;
    mix_pkg::flit_t           lane_out_flit [`MIX_NUM_LANES];
    logic [`MIX_NUM_LANES-1:0] lane_out_ready;

    lane_dispatch u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_valid      (i_valid),
        .i_flit       (i_flit),
        .o_ready      (o_ready),
        .o_lane_valid (lane_in_valid),
        .o_lane_flit  (lane_in_flit),
        .i_lane_ready (lane_in_ready)
    );

    // one mixing lane per slot of the round-robin
    for (genvar g = 0; g < `MIX_NUM_LANES; g++) begin : g_lane
        mix_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (lane_in_valid[g]),
            .i_flit  (lane_in_flit[g]),
            .o_ready (lane_in_ready[g]),
            .o_valid (lane_out_valid[g]),
            .o_flit  (lane_out_flit[g]),
            .i_ready (lane_out_ready[g])
        );
    end

    lane_collect u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_lane_valid (lane_out_valid),
        .i_lane_flit  (lane_out_flit),
        .o_lane_ready (lane_out_ready),
        .o_valid      (o_valid),
        .o_flit       (o_flit),
        .i_ready      (i_ready)
    );

endmodule

//--- hdl/pipe_regs.sv
`timescale 1ns/1ps
`include "mix_consts.svh"

module pipe_regs #(
    parameter int DATA_WIDTH = `MIX_WORD_W
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // upstream handshake
    input  logic                  i_valid,
    output logic                  o_ready_up,

    // downstream handshake
    output logic                  o_valid,
    input  logic                  i_ready_dn,

    // payload
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic [DATA_WIDTH-1:0] o_data
);

    // EMPTY: no data held
    // BUSY: output register holds data
    // FULL: output and buffer registers both hold data
    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        BUSY  = 2'd1,
        FULL  = 2'd2
    } state_t;

    state_t                state;
    state_t                state_next;
    logic [DATA_WIDTH-1:0] buf_data;
    logic                  insert;
    logic                  remove;
    logic                  load;
    logic                  flow;
    logic                  fill;
    logic                  flush;
    logic                  unload;
    logic                  out_wren;

    // transfers on either side of the register
    assign insert = i_valid && o_ready_up;
    assign remove = o_valid && i_ready_dn;

    // load: empty pipe takes new data into output reg
    assign load   = (state == EMPTY) && insert && !remove;
    // flow: new data replaces the data leaving the output reg
    assign flow   = (state == BUSY) && insert && remove;
    // fill: output stalled, new data parks in the buffer reg
    assign fill   = (state == BUSY) && insert && !remove;
    // flush: buffered data moves up as the output leaves
    assign flush  = (state == FULL) && !insert && remove;
    // unload: last data leaves, pipe goes empty
    assign unload = (state == BUSY) && !insert && remove;

    always_comb begin
        state_next = state;
        if (fill) begin
            state_next = FULL;
        end else if (unload) begin
            state_next = EMPTY;
        end else if (load || flush) begin
            state_next = BUSY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // handshake outputs are registered from the next state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_ready_up <= 1'b1;
            o_valid    <= 1'b0;
        end else begin
            o_ready_up <= (state_next != FULL);
            o_valid    <= (state_next != EMPTY);
        end
    end

    assign out_wren = load || flow || flush;

    // skid slot, written only when the output is stalled
    always_ff @(posedge clk) begin
        if (fill) begin
            buf_data <= i_data;
        end
    end

    // output register, the skid slot has priority on flush
    always_ff @(posedge clk) begin
        if (out_wren) begin
            o_data <= flush ? buf_data : i_data;
        end
    end

    // a stalled output keeps its data until the consumer takes it
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready_dn) |=> (o_valid && $stable(o_data)));

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {EMPTY, BUSY, FULL});

endmodule

//--- tb.f
+incdir+hdl
hdl/mix_pkg.sv
hdl/pipe_regs.sv
hdl/mix_lane.sv
hdl/lane_dispatch.sv
hdl/lane_collect.sv
hdl/mix_top.sv
verif/tb_clkgen.sv
verif/tb_mix_top.sv

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD = 50,
    parameter int RST_CYCLES  = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // reset low for a fixed number of rising edges, released just after an edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- verif/tb_mix_top.sv
`timescale 1ns/1ps
`include "mix_consts.svh"

module tb_mix_top;

    // tests take about 1,100 cycles, mostly the 300-flit back-pressure run
    localparam int TIMEOUT_CYCLES = 2000;

    logic           clk;
    logic           rst_n;
    logic           i_valid;
    mix_pkg::flit_t i_flit;
    logic           o_ready;
    logic           o_valid;
    mix_pkg::flit_t o_flit;
    logic           i_ready;

    logic [31:0]    seed = 32'hda53;
    int             cycle = 0;
    int             errors = 0;
    int             checks = 0;
    int             n_out = 0;
    // 0: i_ready high, 1: i_ready random, 2: i_ready held low
    int             bp_mode = 0;
    bit             check_lat = 1'b0;
    mix_pkg::flit_t exp_q[$];
    int             acc_q[$];

    tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

    mix_top i_mix_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_valid),
        .i_flit  (i_flit),
        .o_ready (o_ready),
        .o_valid (o_valid),
        .o_flit  (o_flit),
        .i_ready (i_ready)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic mix_pkg::flit_t rand_flit();
        mix_pkg::flit_t f;
        logic [31:0]    r;
        f.data = lcg_next();
        r = lcg_next();
        f.last = r[20];
        return f;
    endfunction

    // expected lane output: rotl, xor with input, add key, last untouched
    function automatic mix_pkg::flit_t mix_model(input mix_pkg::flit_t f);
        mix_pkg::flit_t m;
        mix_pkg::word_t rot;
        rot = (f.data << `MIX_ROT) | (f.data >> (`MIX_WORD_W - `MIX_ROT));
        m.data = (rot ^ f.data) + `MIX_KEY;
        m.last = f.last;
        return m;
    endfunction

    task automatic compare_flit(input mix_pkg::flit_t got, input mix_pkg::flit_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @%0t: %s got data %h last %b, expected data %h last %b",
                     $time, what, got.data, got.last, exp.data, exp.last);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED @%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-16s done, %0d errors", name, errors - err_before);
    endtask

    // one cycle: move to 1 ns after the next rising edge, then set i_ready
    task automatic step();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = lcg_next();
        case (bp_mode)
            0:       i_ready = 1'b1;
            1:       i_ready = r[16];
            default: i_ready = 1'b0;
        endcase
    endtask

    // hold valid and data until the DUT takes the flit
    task automatic send_flit(input mix_pkg::flit_t f);
        bit taken;
        taken = 1'b0;
        i_valid = 1'b1;
        i_flit  = f;
        while (!taken) begin
            @(negedge clk);
            taken = o_ready;
            step();
        end
        i_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) step();
    endtask

    // mid-cycle monitor, sees the handshakes that complete on the next edge
    always @(negedge clk) begin : monitor
        mix_pkg::flit_t exp;
        int             acc;
        if (rst_n) begin
            if (i_valid && o_ready) begin
                exp_q.push_back(mix_model(i_flit));
                acc_q.push_back(cycle);
            end
            if (o_valid && i_ready) begin
                n_out++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: an output flit came out with none expected", $time);
                end else begin
                    exp = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    compare_flit(o_flit, exp, "o_flit");
                    if (check_lat) compare_count(cycle - acc, 2, "latency in cycles");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin : tests
        mix_pkg::flit_t f;
        int             err0;
        int             out0;
        int             accepted;
        logic [31:0]    r;
        bit             took;
        i_valid = 1'b0;
        i_flit  = '0;
        i_ready = 1'b1;

        // reset state
        err0 = errors;
        wait (rst_n);
        @(negedge clk);
        compare_bit(o_valid, 1'b0, "o_valid after reset");
        compare_bit(o_ready, 1'b1, "o_ready after reset");
        step();
        report_test("reset", err0);

        // one flit at a time, latency measured edge to edge
        err0 = errors;
        check_lat = 1'b1;
        for (int i = 0; i < 8; i++) begin
            f = rand_flit();
            f.last = (i == 7);
            send_flit(f);
            wait_drain();
        end
        check_lat = 1'b0;
        report_test("single_flits", err0);

        // random stream with idle gaps, output always ready
        err0 = errors;
        out0 = n_out;
        for (int i = 0; i < 300; i++) begin
            r = lcg_next();
            if (r[17:16] == 2'd0) step();
            send_flit(rand_flit());
        end
        wait_drain();
        compare_count(n_out - out0, 300, "flits out of random stream");
        report_test("random_stream", err0);

        // random stream with output ready toggling
        err0 = errors;
        out0 = n_out;
        bp_mode = 1;
        for (int i = 0; i < 300; i++) send_flit(rand_flit());
        wait_drain();
        bp_mode = 0;
        compare_count(n_out - out0, 300, "flits out under back-pressure");
        report_test("random_backpress", err0);

        // output blocked: 2 flits per lane plus 2 in the collector register
        err0 = errors;
        out0 = n_out;
        bp_mode = 2;
        step();
        accepted = 0;
        i_valid = 1'b1;
        i_flit = rand_flit();
        repeat (40) begin
            @(negedge clk);
            took = o_ready;
            step();
            if (took) begin
                accepted++;
                i_flit = rand_flit();
            end
        end
        @(negedge clk);
        compare_count(accepted, 10, "flits stored while stalled");
        compare_bit(o_ready, 1'b0, "o_ready when full");
        compare_bit(o_valid, 1'b1, "o_valid when full");
        // release, the held input flit goes in behind the stored ten
        bp_mode = 0;
        send_flit(i_flit);
        wait_drain();
        compare_count(n_out - out0, 11, "flits drained after stall");
        report_test("full_stall", err0);

        $display("tests: 5, checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
